/* filelist.f */
source/audio_ctrl_pkg.sv
source/cmd_reader.sv
source/reply_writer.sv
source/audio_ctrl_top.sv
verif/tb_audio_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_audio_ctrl -f filelist.f -Mdir obj_dir

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/Vtb_audio_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"

/* verif/tb_audio_ctrl.sv */
// Testbench for the playback command controller
// Host input FIFO is a queue shown first-word-fall-through, popped after each read edge
// Back-pressure on the stream port and the output FIFO is random from a Fibonacci LFSR
// Expected stream bytes, config and reply bytes come from a byte-level model
// The last command is a malformed setup, so the run ends with the DUT halted

`timescale 1ns/1ps

module tb_audio_ctrl;
    import audio_ctrl_pkg::*;

    logic        clk;
    logic        reset_i;
    logic        in_empty_i;
    logic [7:0]  in_data_i;
    logic        in_rd_en_o;
    logic        out_full_i;
    logic        out_afull_i;
    logic        out_wr_en_o;
    logic [7:0]  out_data_o;
    logic        stream_full_i;
    logic        stream_valid_o;
    logic [7:0]  stream_data_o;
    out_kind_e   out_kind_o;
    logic        channels_o;
    logic [2:0]  sample_rate_o;
    logic [1:0]  bit_depth_o;
    logic        err_led_o;

    // Host FIFO and expected results
    logic [7:0]  in_q [$];
    logic [7:0]  exp_stream [$];
    logic [7:0]  exp_cfg [$];
    logic [7:0]  exp_reply [$];
    logic        rd_taken;
    logic [31:0] lfsr = 32'h5265;
    int          cycles = 0;
    int          cycle_limit = 0;

    // Model state
    logic        m_payload = 1'b0;
    logic        m_halt = 1'b0;
    cmd_e        m_cmd = SETUP_OUTPUT;
    logic [5:0]  m_rem = '0;
    out_kind_e   m_kind = OUT_NONE;
    logic [5:0]  m_cfg = '0;
    int          m_tail = 0;

    audio_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Read strobe as seen by the DUT on the rising edge
    always @(posedge clk) begin
        rd_taken <= in_rd_en_o;
    end

    // ============================================================
    // Random numbers and checking
    // ============================================================

    // Taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = 8'h00;
        for (int k = 0; k < n; k++) begin
            r = {r[6:0], next_bit()};
        end
        return r;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
        if (exp_v !== act_v) begin
            $display("error %s expected %02h actual %02h", name, exp_v, act_v);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // ============================================================
    // Stimulus and reference model
    // ============================================================

    // Queue one byte and run it through the model
    task automatic send(input logic [7:0] b);
        in_q.push_back(b);
        if (m_halt) begin
            // Never read once halted
            m_tail++;
        end else if (!m_payload) begin
            m_cmd = cmd_e'(b[7:6]);
            m_rem = b[5:0];
            if (m_cmd == STOP) begin
                exp_reply.push_back(8'hC1);
                exp_reply.push_back((m_rem == 6'd0) ? 8'h00 : 8'h02);
                m_halt = (m_rem != 6'd0);
            end else if ((m_cmd == SETUP_OUTPUT) && (m_rem != 6'd1)) begin
                exp_reply.push_back(8'hC1);
                exp_reply.push_back(8'h01);
                m_halt = 1'b1;
            end else begin
                m_payload = (m_rem != 6'd0);
            end
        end else begin
            m_rem = m_rem - 6'd1;
            m_payload = (m_rem != 6'd0);
            if (m_cmd == SETUP_OUTPUT) begin
                // Only I2S has its own path
                m_kind = (b[7:6] == 2'd3) ? OUT_I2S : OUT_SPDIF;
                m_cfg = b[5:0];
            end else if ((m_cmd == STREAM_OUTPUT) && (m_kind != OUT_NONE)) begin
                exp_stream.push_back(b);
                exp_cfg.push_back({m_kind, m_cfg});
            end
        end
    endtask

    task automatic send_stream(input logic [5:0] n);
        send({2'b10, n});
        repeat (n) begin
            send(rand_bits(8));
        end
    endtask

    // One clock of checking, FIFO upkeep and input drive
    task automatic step_cycle();
        logic [7:0] byte_v;
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            abort("timeout, the DUT did not finish the command stream in time");
        end else begin
            // Flags still hold the values seen on the last rising edge
            if (stream_valid_o && stream_full_i) begin
                abort("DUT took a stream byte while the stream port was full");
            end
            if (out_wr_en_o && (out_full_i || out_afull_i)) begin
                abort("DUT wrote the output FIFO while it was full or almost full");
            end
            if (rd_taken) begin
                if (in_q.size() == 0) begin
                    abort("DUT read the input FIFO while it was empty");
                end else begin
                    byte_v = in_q.pop_front();
                end
            end
            if (stream_valid_o) begin
                if (exp_stream.size() == 0) begin
                    abort("DUT forwarded a stream byte that should have been dropped");
                end else begin
                    byte_v = exp_stream.pop_front();
                    check("stream data", byte_v, stream_data_o);
                    byte_v = exp_cfg.pop_front();
                    check("output config", byte_v,
                          {out_kind_o, channels_o, sample_rate_o, bit_depth_o});
                end
            end
            if (out_wr_en_o) begin
                if (exp_reply.size() == 0) begin
                    abort("DUT wrote an extra reply byte to the output FIFO");
                end else begin
                    byte_v = exp_reply.pop_front();
                    check("reply byte", byte_v, out_data_o);
                end
            end
            in_empty_i    = (in_q.size() == 0);
            in_data_i     = (in_q.size() == 0) ? 8'h00 : in_q[0];
            stream_full_i = next_bit();
            out_full_i    = next_bit();
            out_afull_i   = next_bit();
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [7:0] io_base;
        logic [7:0] r;
        logic [1:0] io;
        logic [5:0] n;
        reset_i       = 1'b1;
        in_empty_i    = 1'b1;
        in_data_i     = 8'h00;
        out_full_i    = 1'b0;
        out_afull_i   = 1'b0;
        stream_full_i = 1'b0;

        // Stream before any setup, consumed and dropped
        send_stream(6'd3);
        // Four setups walk all IO types, each followed by a stream
        io_base = rand_bits(2);
        for (int i = 0; i < 4; i++) begin
            io = 2'(i) ^ io_base[1:0];
            r = rand_bits(6);
            send(8'h01);
            send({io, r[5:0]});
            r = rand_bits(4);
            send_stream(r[5:0] + 6'd1);
        end
        // Good stop, then setup-input is skipped and streaming goes on
        send(8'hC0);
        r = rand_bits(2);
        n = r[5:0] + 6'd1;
        send({2'b01, n});
        repeat (n) begin
            send(rand_bits(8));
        end
        send_stream(6'd5);
        send(8'hC0);
        // Setup with length 3 halts the parser
        send(8'h03);
        repeat (4) begin
            send(rand_bits(8));
        end
        cycle_limit = 40 * in_q.size();

        // First byte is already offered while reset is held
        in_empty_i = 1'b0;
        in_data_i  = in_q[0];

        repeat (4) @(posedge clk);
        @(negedge clk);
        check("reset state", 8'h00,
              {in_rd_en_o, out_wr_en_o, stream_valid_o, err_led_o, 2'b00, out_kind_o});
        reset_i = 1'b0;

        while (!(err_led_o && (exp_reply.size() == 0) && (exp_stream.size() == 0))) begin
            step_cycle();
        end
        check("bytes left at halt", 8'(m_tail), 8'(in_q.size()));
        repeat (50) step_cycle();
        check("bytes left after halt", 8'(m_tail), 8'(in_q.size()));
        check("error led", 8'h01, {7'd0, err_led_o});
        $display("sim passed");
        $finish;
    end

endmodule

/* source/audio_ctrl_top.sv */
// Top level of the playback command controller, single clock domain
// Host FIFOs, the sample stream and the output config are plain ports
// No clock generation or audio transmitters live here
// in_rd_en_o is combinational, all other outputs are registered

`timescale 1ns/1ps

module audio_ctrl_top (
    input  logic                                 clk,
    input  logic                                 reset_i,
    // Host input FIFO
    input  logic                                 in_empty_i,
    input  logic [7:0]                           in_data_i,
    output logic                                 in_rd_en_o,
    // Host output FIFO
    input  logic                                 out_full_i,
    input  logic                                 out_afull_i,
    output logic                                 out_wr_en_o,
    output logic [7:0]                           out_data_o,
    // Audio sample stream
    input  logic                                 stream_full_i,
    output logic                                 stream_valid_o,
    output logic [7:0]                           stream_data_o,
    // Output configuration
    output audio_ctrl_pkg::out_kind_e            out_kind_o,
    output logic                                 channels_o,
    output logic [audio_ctrl_pkg::RATE_W-1:0]    sample_rate_o,
    output logic [audio_ctrl_pkg::DEPTH_W-1:0]   bit_depth_o,
    // Status
    output logic                                 err_led_o
);
    import audio_ctrl_pkg::*;

    // Reader to writer handshake
    logic      reply_req;
    err_code_e reply_code;
    logic      reply_done;

    // ============================================================
    // Command parser
    // ============================================================

    cmd_reader u_cmd_reader (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_empty_i     (in_empty_i),
        .in_data_i      (in_data_i),
        .in_rd_en_o     (in_rd_en_o),
        .stream_full_i  (stream_full_i),
        .stream_valid_o (stream_valid_o),
        .stream_data_o  (stream_data_o),
        .out_kind_o     (out_kind_o),
        .channels_o     (channels_o),
        .sample_rate_o  (sample_rate_o),
        .bit_depth_o    (bit_depth_o),
        .reply_req_o    (reply_req),
        .reply_code_o   (reply_code),
        .reply_done_i   (reply_done),
        .err_led_o      (err_led_o)
    );

    // ============================================================
    // Status reply path
    // ============================================================

    reply_writer u_reply_writer (
        .clk          (clk),
        .reset_i      (reset_i),
        .reply_req_i  (reply_req),
        .reply_code_i (reply_code),
        .reply_done_o (reply_done),
        .out_full_i   (out_full_i),
        .out_afull_i  (out_afull_i),
        .out_wr_en_o  (out_wr_en_o),
        .out_data_o   (out_data_o)
    );

endmodule

/* source/reply_writer.sv */
// Two-byte status reply writer for the host output FIFO
// A request is ignored while a reply is still in progress
// Bytes go out only after edges with both out_full_i and out_afull_i low
// reply_done_o pulses one cycle after the last write strobe

`timescale 1ns/1ps

module reply_writer (
    input  logic                      clk,
    input  logic                      reset_i,
    // Request from the reader
    input  logic                      reply_req_i,
    input  audio_ctrl_pkg::err_code_e reply_code_i,
    output logic                      reply_done_o,
    // Output FIFO
    input  logic                      out_full_i,
    input  logic                      out_afull_i,
    output logic                      out_wr_en_o,
    output logic [7:0]                out_data_o
);
    import audio_ctrl_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_DONE
    } wr_state_e;

    wr_state_e  state_q;
    // Byte index into the reply buffer
    logic       idx_q;
    logic [7:0] reply_buf [0:1];
    logic       can_write;

    // Almost-full counts as full, the FIFO flag may lag by a cycle
    assign can_write = !out_full_i && !out_afull_i;

    // ============================================================
    // Reply buffer
    // ============================================================

    // Header then code, loaded once per request
    always_ff @(posedge clk) begin
        if (reply_req_i && (state_q == WR_IDLE)) begin
            reply_buf[0] <= REPLY_HDR;
            reply_buf[1] <= reply_code_i;
        end
    end

    // Data follows the buffer entry chosen on the write edge
    always_ff @(posedge clk) begin
        if ((state_q == WR_SEND) && can_write) begin
            out_data_o <= reply_buf[idx_q];
        end
    end

    // ============================================================
    // Write sequencer
    // ============================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= WR_IDLE;
            idx_q        <= 1'b0;
            out_wr_en_o  <= 1'b0;
            reply_done_o <= 1'b0;
        end else begin
            out_wr_en_o  <= 1'b0;
            reply_done_o <= 1'b0;

            case (state_q)
                WR_IDLE: begin
                    if (reply_req_i) begin
                        idx_q   <= 1'b0;
                        state_q <= WR_SEND;
                    end
                end

                WR_SEND: begin
                    // Wait out back-pressure, one byte per free edge
                    if (can_write) begin
                        out_wr_en_o <= 1'b1;
                        idx_q       <= 1'b1;
                        if (idx_q) begin
                            state_q <= WR_DONE;
                        end
                    end
                end

                default: begin
                    // Last byte strobed, release the reader
                    reply_done_o <= 1'b1;
                    state_q      <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/cmd_reader.sv */
// Command parser on the host input FIFO side
// Input FIFO must be first-word-fall-through; a byte is taken on each edge with in_rd_en_o
// in_rd_en_o is combinational from state, in_empty_i and stream_full_i
// Stream bytes are dropped while no output has been set up
// Any malformed setup or stop halts parsing until reset_i

`timescale 1ns/1ps

module cmd_reader (
    input  logic                                 clk,
    input  logic                                 reset_i,
    // Input FIFO
    input  logic                                 in_empty_i,
    input  logic [7:0]                           in_data_i,
    output logic                                 in_rd_en_o,
    // Audio sample stream
    input  logic                                 stream_full_i,
    output logic                                 stream_valid_o,
    output logic [7:0]                           stream_data_o,
    // Output configuration
    output audio_ctrl_pkg::out_kind_e            out_kind_o,
    output logic                                 channels_o,
    output logic [audio_ctrl_pkg::RATE_W-1:0]    sample_rate_o,
    output logic [audio_ctrl_pkg::DEPTH_W-1:0]   bit_depth_o,
    // Reply request to the writer
    output logic                                 reply_req_o,
    output audio_ctrl_pkg::err_code_e            reply_code_o,
    input  logic                                 reply_done_i,
    output logic                                 err_led_o
);
    import audio_ctrl_pkg::*;

    // Reader control, idle lasts one cycle after reset
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT_REPLY,
        ST_HALT
    } rd_state_e;

    // Byte-level protocol position
    typedef enum logic {
        PR_HEADER,
        PR_PAYLOAD
    } proto_e;

    rd_state_e        state_q;
    proto_e           proto_q;
    cmd_e             last_cmd_q;
    logic [LEN_W-1:0] remaining_q;

    cmd_e             hdr_cmd;
    logic [LEN_W-1:0] hdr_len;
    logic             stall;
    logic             take_header;
    logic             take_payload;

    // Map the physical IO type onto the transmitter that would serve it
    function automatic out_kind_e decode_io(input io_type_e io);
        out_kind_e kind;
        case (io)
            AES3, BNC, TOSLINK: kind = OUT_SPDIF;
            default:            kind = OUT_I2S;
        endcase
        return kind;
    endfunction

    // ============================================================
    // Read enable and byte classification
    // ============================================================

    // Header fields, only meaningful when the head byte is a header
    assign hdr_cmd = cmd_e'(in_data_i[7:6]);
    assign hdr_len = in_data_i[LEN_W-1:0];

    // Back-pressure only holds off stream payload bytes
    assign stall = (proto_q == PR_PAYLOAD) && (last_cmd_q == STREAM_OUTPUT) && stream_full_i;

    assign in_rd_en_o   = (state_q == ST_READ) && !in_empty_i && !stall;
    assign take_header  = in_rd_en_o && (proto_q == PR_HEADER);
    assign take_payload = in_rd_en_o && (proto_q == PR_PAYLOAD);

    // ============================================================
    // Parser FSM
    // ============================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q        <= ST_IDLE;
            proto_q        <= PR_HEADER;
            last_cmd_q     <= SETUP_OUTPUT;
            remaining_q    <= '0;
            stream_valid_o <= 1'b0;
            out_kind_o     <= OUT_NONE;
            channels_o     <= 1'b0;
            sample_rate_o  <= '0;
            bit_depth_o    <= '0;
            reply_req_o    <= 1'b0;
            reply_code_o   <= ERR_NONE;
            err_led_o      <= 1'b0;
        end else begin
            // Single-cycle strobes
            stream_valid_o <= 1'b0;
            reply_req_o    <= 1'b0;

            case (state_q)
                ST_IDLE: begin
                    state_q <= ST_READ;
                end

                ST_READ: begin
                    if (take_header) begin
                        last_cmd_q  <= hdr_cmd;
                        remaining_q <= hdr_len;
                        case (hdr_cmd)
                            SETUP_OUTPUT: begin
                                // Exactly one config byte expected
                                if (hdr_len == LEN_W'(1)) begin
                                    proto_q <= PR_PAYLOAD;
                                end else begin
                                    reply_req_o  <= 1'b1;
                                    reply_code_o <= ERR_SETUP_PAYLOAD;
                                    err_led_o    <= 1'b1;
                                    state_q      <= ST_WAIT_REPLY;
                                end
                            end
                            STOP: begin
                                // Always answered, the code tells good from bad
                                reply_req_o <= 1'b1;
                                state_q     <= ST_WAIT_REPLY;
                                if (hdr_len == '0) begin
                                    reply_code_o <= ERR_NONE;
                                end else begin
                                    reply_code_o <= ERR_STOP_PAYLOAD;
                                    err_led_o    <= 1'b1;
                                end
                            end
                            default: begin
                                // Stream and setup-input, empty payload is a no-op
                                if (hdr_len != '0) begin
                                    proto_q <= PR_PAYLOAD;
                                end
                            end
                        endcase
                    end else if (take_payload) begin
                        remaining_q <= remaining_q - LEN_W'(1);
                        if (remaining_q == LEN_W'(1)) begin
                            proto_q <= PR_HEADER;
                        end
                        case (last_cmd_q)
                            SETUP_OUTPUT: begin
                                out_kind_o    <= decode_io(io_type_e'(in_data_i[7:6]));
                                channels_o    <= in_data_i[5];
                                sample_rate_o <= in_data_i[4:2];
                                bit_depth_o   <= in_data_i[1:0];
                            end
                            STREAM_OUTPUT: begin
                                // Without an output the byte is consumed and lost
                                if (out_kind_o != OUT_NONE) begin
                                    stream_valid_o <= 1'b1;
                                end
                            end
                            default: begin
                                // Setup-input payload is skipped
                            end
                        endcase
                    end
                end

                ST_WAIT_REPLY: begin
                    // LED set means this reply reported an error
                    if (reply_done_i) begin
                        state_q <= err_led_o ? ST_HALT : ST_READ;
                    end
                end

                default: begin
                    // Halted, only reset leaves this state
                end
            endcase
        end
    end

    // Stream byte register, qualified by stream_valid_o
    always_ff @(posedge clk) begin
        if (take_payload && (last_cmd_q == STREAM_OUTPUT)) begin
            stream_data_o <= in_data_i;
        end
    end

endmodule

/* source/audio_ctrl_pkg.sv */
// Shared definitions for the playback command controller
// Header byte layout is {cmd[1:0], len[5:0]}; a length of 0 means no payload
// Setup-output payload layout is {io_type[1:0], channels, rate[2:0], depth[1:0]}
// Error codes are one byte wide because they travel as the second reply byte

package audio_ctrl_pkg;

    // ============================================================
    // Field widths
    // ============================================================

    // Payload length field in the header byte
    localparam int LEN_W = 6;
    // Sample-rate code, bit 2 picks the 48 kHz family, bits 1:0 the multiple
    localparam int RATE_W = 3;
    // Bit-depth code
    localparam int DEPTH_W = 2;

    // ============================================================
    // Encodings
    // ============================================================

    // Command in header bits 7:6
    typedef enum logic [1:0] {
        SETUP_OUTPUT  = 2'd0,
        SETUP_INPUT   = 2'd1,
        STREAM_OUTPUT = 2'd2,
        STOP          = 2'd3
    } cmd_e;

    // Physical IO type in setup payload bits 7:6
    typedef enum logic [1:0] {
        AES3    = 2'd0,
        BNC     = 2'd1,
        TOSLINK = 2'd2,
        I2S     = 2'd3
    } io_type_e;

    // Active output, the three coax/optical types share one S/PDIF path
    typedef enum logic [1:0] {
        OUT_NONE  = 2'd0,
        OUT_SPDIF = 2'd1,
        OUT_I2S   = 2'd2
    } out_kind_e;

    // Status code sent as the second reply byte
    typedef enum logic [7:0] {
        ERR_NONE          = 8'd0,
        ERR_SETUP_PAYLOAD = 8'd1,
        ERR_STOP_PAYLOAD  = 8'd2
    } err_code_e;

    // Reply header, STOP command with a one-byte payload
    localparam logic [7:0] REPLY_HDR = 8'hC1;

endpackage
